// ==== lsu_pkg.sv ====
/*
 * Load/store unit core-side package
 * Access types, data widths and the request, response and part structs
 * exchanged between the core, the controller and the datapath.
 */
package lsu_pkg;

  localparam int unsigned xlen_w   = 32; // data and address width
  localparam int unsigned offset_w = 2;  // byte offset inside a word

  // access size, encoding follows the core's decoder
  typedef enum logic [1:0] {
    lsu_word = 2'b00,
    lsu_half = 2'b01,
    lsu_byte = 2'b10
  } lsu_type_e;

  // one access from the core, held until done
  typedef struct packed {
    logic              we;       // store when set
    lsu_type_e         lsu_type;
    logic              sign_ext; // sign-extend sub-word loads
    logic [xlen_w-1:0] addr;     // byte address
    logic [xlen_w-1:0] wdata;    // store data, lane 0 aligned
  } lsu_req_t;

  // response to the core, one resp_valid pulse per access
  typedef struct packed {
    logic              resp_valid;
    logic              rdata_valid;
    logic [xlen_w-1:0] rdata;
    logic              load_err;
    logic              store_err;
  } lsu_resp_t;

  // which part of an access the controller is issuing
  typedef struct packed {
    logic second_part; // upper word of a split access
    logic misaligned;  // access is split into two transfers
  } ls_part_t;

endpackage

// ==== mem_bus_pkg.sv ====
/*
 * Data memory bus package
 * Word bus widths, outstanding-transfer limit and the request struct
 * driven towards memory.
 */
package mem_bus_pkg;

  localparam int unsigned bus_addr_w = 32;
  localparam int unsigned bus_data_w = 32;
  localparam int unsigned be_w       = bus_data_w / 8; // one enable per byte lane

  // a split access keeps at most two transfers in flight
  localparam int unsigned bus_outst_max = 2;
  localparam int unsigned outst_cnt_w   = $clog2(bus_outst_max + 1);

  // request side of the bus, payload valid while req is high
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [bus_addr_w-1:0] addr;  // word aligned
    logic [be_w-1:0]       be;
    logic [bus_data_w-1:0] wdata; // already rotated into its lanes
  } bus_req_t;

endpackage

// ==== lsu_ctrl.sv ====
/*
 * Load/store unit control FSM
 * Splits misaligned accesses into two bus transfers, sequences grants and
 * rvalids, and tracks the error status of each access.
 */
`timescale 1ns/1ps

module lsu_ctrl
  import lsu_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                lsu_req_i,
  input  lsu_type_e           req_type_i,
  input  logic [offset_w-1:0] req_offset_i,
  input  logic                req_we_i,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  input  logic                data_err_i,
  output logic                bus_req_o,
  output ls_part_t            part_o,
  output logic                addr_update_o,
  output logic                ctrl_update_o,
  output logic                rdata_update_o,
  output logic                req_done_o,
  output logic                resp_valid_o,
  output logic                rdata_valid_o,
  output logic                load_err_o,
  output logic                store_err_o,
  output logic                busy_o
);

  typedef enum logic [2:0] {
    s_idle,
    s_wait_gnt_mis,              // first part of a split access not granted yet
    s_wait_rvalid_mis,           // first part granted, second part requested
    s_wait_gnt,                  // single part, or second part after first rvalid
    s_wait_rvalid_mis_gnts_done  // both granted, first rvalid still pending
  } ls_fsm_e;

  ls_fsm_e                state_q, state_d;
  logic                   split;            // access needs two transfers
  logic                   split_q, split_d;
  logic                   err_q, err_d;     // first part came back with an error
  logic                   we_q;
  logic                   any_err;
  logic                   issue;            // transfer granted this cycle
  logic [outst_cnt_w-1:0] outst_q;          // granted transfers awaiting rvalid

  // word off its boundary, or a half word crossing into the next word
  assign split = ((req_type_i == lsu_word) && (req_offset_i != '0)) ||
                 ((req_type_i == lsu_half) && (req_offset_i == {offset_w{1'b1}}));

  assign part_o.misaligned  = (state_q == s_idle) ? split : split_q;
  assign part_o.second_part = (state_q == s_wait_rvalid_mis) ||
                              (state_q == s_wait_rvalid_mis_gnts_done) ||
                              ((state_q == s_wait_gnt) && split_q);

  //////////////////////////////////////////////////
  // state sequencing
  //////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    split_d        = split_q;
    err_d          = err_q;
    bus_req_o      = 1'b0;
    addr_update_o  = 1'b0;
    ctrl_update_o  = 1'b0;
    rdata_update_o = 1'b0;

    unique case (state_q)
      s_idle: begin
        if (lsu_req_i) begin
          bus_req_o = 1'b1;
          split_d   = split;
          err_d     = 1'b0; // fresh access
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update_o = 1'b1;
            state_d       = split ? s_wait_rvalid_mis : s_idle;
          end else begin
            state_d       = split ? s_wait_gnt_mis : s_wait_gnt;
          end
        end
      end

      s_wait_gnt_mis: begin
        bus_req_o = 1'b1; // hold first part
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update_o = 1'b1;
          state_d       = s_wait_rvalid_mis;
        end
      end

      s_wait_rvalid_mis: begin
        bus_req_o = 1'b1; // second part overlaps the first one's data phase
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;                    // keep upper bytes of first word
          addr_update_o  = data_gnt_i & ~data_err_i; // first failing address wins
          state_d        = data_gnt_i ? s_idle : s_wait_gnt;
        end else if (data_gnt_i) begin
          state_d = s_wait_rvalid_mis_gnts_done;
        end
      end

      s_wait_gnt: begin
        bus_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update_o = ~err_q;
          state_d       = s_idle;
        end
      end

      s_wait_rvalid_mis_gnts_done: begin
        // no request here, only the first rvalid is awaited
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          addr_update_o  = ~data_err_i;
          rdata_update_o = ~we_q;
          state_d        = s_idle;
        end
      end

      default: state_d = s_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= s_idle;
      split_q <= 1'b0;
      err_q   <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      split_q <= split_d;
      err_q   <= err_d;
      if (ctrl_update_o) begin
        we_q <= req_we_i;
      end
    end
  end

  // in-flight count, one up per grant and one down per rvalid
  assign issue = bus_req_o & data_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q <= '0;
    end else if (issue != data_rvalid_i) begin
      outst_q <= issue ? outst_q + 1'b1 : outst_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // core side outputs
  //////////////////////////////////////////////////

  // done on the grant of the last part
  assign req_done_o    = issue & (~part_o.misaligned | part_o.second_part);
  assign resp_valid_o  = data_rvalid_i & (state_q == s_idle); // final rvalid only
  assign any_err       = err_q | data_err_i;                  // either part failed
  assign rdata_valid_o = resp_valid_o & ~any_err & ~we_q;
  assign load_err_o    = resp_valid_o & any_err & ~we_q;
  assign store_err_o   = resp_valid_o & any_err & we_q;
  assign busy_o        = (state_q != s_idle) | (outst_q != '0);

  state_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(state_q));

  // a response in idle needs a granted transfer still in flight
  no_stray_rvalid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == s_idle) && data_rvalid_i |-> (outst_q != '0));

endmodule

// ==== lsu_addr_gen.sv ====
/*
 * Load/store unit address generation
 * Word-aligned bus address per part and the last-address register.
 */
`timescale 1ns/1ps

module lsu_addr_gen
  import lsu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic [xlen_w-1:0] addr_i,
  input  ls_part_t          part_i,
  input  logic              addr_update_i,
  output logic [xlen_w-1:0] bus_addr_o,
  output logic [xlen_w-1:0] addr_last_o
);

  logic [xlen_w-1:0] addr_last_q;
  logic [xlen_w-1:0] next_word; // word after the recorded first part

  // addr_last_q holds the first part's address once the first grant is seen
  assign next_word  = {addr_last_q[xlen_w-1:offset_w] + 1'b1, {offset_w{1'b0}}};
  assign bus_addr_o = part_i.second_part ? next_word
                                         : {addr_i[xlen_w-1:offset_w], {offset_w{1'b0}}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update_i) begin
      addr_last_q <= part_i.second_part ? next_word : addr_i; // byte addr for the first part
    end
  end

  assign addr_last_o = addr_last_q;

  // a second part only follows a recorded misaligned first part
  second_after_first_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    part_i.second_part |-> part_i.misaligned && (addr_last_q[offset_w-1:0] != '0));

endmodule

// ==== lsu_store_align.sv ====
/*
 * Load/store unit store alignment
 * Byte enables per part and rotation of store data into its lanes.
 */
`timescale 1ns/1ps

module lsu_store_align
  import lsu_pkg::*;
  import mem_bus_pkg::*;
(
  input  lsu_type_e           type_i,
  input  logic [offset_w-1:0] offset_i,
  input  ls_part_t            part_i,
  input  logic [xlen_w-1:0]   wdata_i,
  output logic [be_w-1:0]     be_o,
  output logic [xlen_w-1:0]   wdata_o
);

  logic [be_w-1:0]     lane_mask; // lanes covered at offset 0
  logic [2*be_w-1:0]   be_span;   // low half first word, high half spill
  logic [2*xlen_w-1:0] wdata_rot;

  always_comb begin
    unique case (type_i)
      lsu_word: lane_mask = {be_w{1'b1}};
      lsu_half: lane_mask = be_w'(2'b11);
      default:  lane_mask = be_w'(1'b1);  // byte
    endcase
  end

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  // e.g. word at offset 1 spans 0001_1110
  assign be_span = {{be_w{1'b0}}, lane_mask} << offset_i;

  // second part gets the lanes that spilled into the next word
  assign be_o = part_i.second_part ? be_span[2*be_w-1:be_w]
                                   : be_span[be_w-1:0];

  //////////////////////////////////////////////////
  // store data rotation
  //////////////////////////////////////////////////

  // rotate left by offset bytes, the same data serves both parts
  assign wdata_rot = {wdata_i, wdata_i} << {offset_i, 3'b000};
  assign wdata_o   = wdata_rot[2*xlen_w-1:xlen_w];

endmodule

// ==== lsu_load_align.sv ====
/*
 * Load/store unit load alignment
 * Joins the two words of a split load, extracts the byte, half word or
 * word and sign- or zero-extends it.
 */
`timescale 1ns/1ps

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                ctrl_update_i,
  input  logic                rdata_update_i,
  input  lsu_type_e           type_i,
  input  logic [offset_w-1:0] offset_i,
  input  logic                sign_ext_i,
  input  logic [xlen_w-1:0]   rdata_i,
  output logic [xlen_w-1:0]   rdata_o
);

  logic [offset_w-1:0] offset_q;
  lsu_type_e           type_q;
  logic                sign_q;
  logic [xlen_w-1:8]   rdata_q;   // upper three bytes of the first word
  logic [2*xlen_w-1:0] win;       // second word on top of the saved bytes
  logic [2*xlen_w-1:0] win_sh;
  logic [xlen_w-1:0]   rdata_sh;  // single word shifted down to lane 0
  logic [xlen_w-1:0]   word_val;
  logic [15:0]         half_val;
  logic [7:0]          byte_val;

  // access attributes, captured at grant so the core may move on
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
      type_q   <= lsu_word;
      sign_q   <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q <= offset_i;
      type_q   <= type_i;
      sign_q   <= sign_ext_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= rdata_i[xlen_w-1:8];
    end
  end

  //////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////

  assign win      = {rdata_i, rdata_q, 8'h00};
  assign win_sh   = win >> {offset_q, 3'b000};
  assign rdata_sh = rdata_i >> {offset_q, 3'b000};

  // only split accesses draw on rdata_q
  assign word_val = (offset_q == '0) ? rdata_sh : win_sh[xlen_w-1:0];
  assign half_val = (offset_q == {offset_w{1'b1}}) ? win_sh[15:0] : rdata_sh[15:0];
  assign byte_val = rdata_sh[7:0]; // bytes never cross a word

  // width select and extension
  always_comb begin
    unique case (type_q)
      lsu_word: rdata_o = word_val;
      lsu_half: rdata_o = {{16{sign_q & half_val[15]}}, half_val};
      default:  rdata_o = {{24{sign_q & byte_val[7]}}, byte_val};
    endcase
  end

endmodule

// ==== lsu_top.sv ====
/*
 * Load/store unit top level
 * Connects the control FSM to the address, store and load datapaths.
 */
`timescale 1ns/1ps

module lsu_top
  import lsu_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              lsu_req_i,
  input  lsu_req_t          lsu_req_data_i,
  output logic              lsu_req_done_o,
  output lsu_resp_t         lsu_resp_o,
  output bus_req_t          bus_req_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  logic              data_err_i,
  input  logic [xlen_w-1:0] data_rdata_i,
  output logic [xlen_w-1:0] addr_last_o,
  output logic              busy_o
);

  ls_part_t          part;
  logic              bus_req;
  logic              addr_update;
  logic              ctrl_update;
  logic              rdata_update;
  logic              resp_valid;
  logic              rdata_valid;
  logic              load_err;
  logic              store_err;
  logic [xlen_w-1:0] bus_addr;
  logic [xlen_w-1:0] bus_wdata;
  logic [xlen_w-1:0] rdata;
  logic [be_w-1:0]   bus_be;

  lsu_ctrl lsu_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_req_i      (lsu_req_i),
    .req_type_i     (lsu_req_data_i.lsu_type),
    .req_offset_i   (lsu_req_data_i.addr[offset_w-1:0]),
    .req_we_i       (lsu_req_data_i.we),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .bus_req_o      (bus_req),
    .part_o         (part),
    .addr_update_o  (addr_update),
    .ctrl_update_o  (ctrl_update),
    .rdata_update_o (rdata_update),
    .req_done_o     (lsu_req_done_o),
    .resp_valid_o   (resp_valid),
    .rdata_valid_o  (rdata_valid),
    .load_err_o     (load_err),
    .store_err_o    (store_err),
    .busy_o         (busy_o)
  );

  lsu_addr_gen lsu_addr_gen_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .addr_i        (lsu_req_data_i.addr),
    .part_i        (part),
    .addr_update_i (addr_update),
    .bus_addr_o    (bus_addr),
    .addr_last_o   (addr_last_o)
  );

  lsu_store_align lsu_store_align_i (
    .type_i   (lsu_req_data_i.lsu_type),
    .offset_i (lsu_req_data_i.addr[offset_w-1:0]),
    .part_i   (part),
    .wdata_i  (lsu_req_data_i.wdata),
    .be_o     (bus_be),
    .wdata_o  (bus_wdata)
  );

  lsu_load_align lsu_load_align_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .type_i         (lsu_req_data_i.lsu_type),
    .offset_i       (lsu_req_data_i.addr[offset_w-1:0]),
    .sign_ext_i     (lsu_req_data_i.sign_ext),
    .rdata_i        (data_rdata_i),
    .rdata_o        (rdata)
  );

  // we comes straight from the core, held while req is up
  assign bus_req_o = '{req: bus_req, we: lsu_req_data_i.we, addr: bus_addr,
                       be: bus_be, wdata: bus_wdata};

  assign lsu_resp_o = '{resp_valid: resp_valid, rdata_valid: rdata_valid, rdata: rdata,
                        load_err: load_err, store_err: store_err};

endmodule

// ==== tb_lsu_tasks.svh ====
/*
 * Load/store unit testbench tasks
 * Reference memory rules, core-side access, value check and directed tests.
 */

// error window covers bytes 0x300 to 0x30f
function automatic logic in_err_window(input logic [xlen_w-1:0] addr);
  return addr[xlen_w-1:4] == 28'h0000030;
endfunction

function automatic int unsigned size_bytes(input lsu_type_e t);
  case (t)
    lsu_word: return 4;
    lsu_half: return 2;
    default:  return 1;
  endcase
endfunction

// any byte of the access inside the error window
function automatic logic access_fails(input lsu_type_e t, input logic [xlen_w-1:0] addr);
  for (int unsigned i = 0; i < size_bytes(t); i++) begin
    if (in_err_window(addr + i)) return 1'b1;
  end
  return 1'b0;
endfunction

// little endian bytes from the reference, then extension
function automatic logic [xlen_w-1:0] expect_load(input lsu_type_e t, input logic sx,
                                                  input logic [xlen_w-1:0] addr);
  logic [xlen_w-1:0] val;
  int unsigned       n;
  val = '0;
  n   = size_bytes(t);
  for (int unsigned i = 0; i < n; i++) val[8*i +: 8] = ref_mem[10'(addr + i)];
  if (sx && val[8*n-1]) begin
    for (int unsigned i = 8 * n; i < xlen_w; i++) val[i] = 1'b1;
  end
  return val;
endfunction

// lanes 3:0 first word, 7:4 the spill into the next one
function automatic logic [2*be_w-1:0] expect_be(input lsu_type_e t, input logic [1:0] offset);
  logic [2*be_w-1:0] lanes;
  lanes = '0;
  for (int unsigned i = 0; i < size_bytes(t); i++) lanes[32'(offset) + i] = 1'b1;
  return lanes;
endfunction

task automatic store_ref(input lsu_type_e t, input logic [xlen_w-1:0] addr,
                         input logic [xlen_w-1:0] wdata);
  for (int unsigned i = 0; i < size_bytes(t); i++) begin
    if (!in_err_window(addr + i)) ref_mem[10'(addr + i)] = wdata[8*i +: 8];
  end
endtask

task automatic check_val(input string name, input logic [xlen_w-1:0] exp,
                         input logic [xlen_w-1:0] act);
  if (exp !== act) begin
    $display("Fail %s: expected %h, actual %h", name, exp, act);
    $display("TEST FAIL");
    $fatal(1);
  end
endtask

// request held until done, then wait for the response pulse
task automatic do_access(input logic we, input lsu_type_e t, input logic sx,
                         input logic [xlen_w-1:0] addr, input logic [xlen_w-1:0] wdata);
  @(posedge clk_i);
  be_log.delete();
  lsu_req_i      <= 1'b1;
  lsu_req_data_i <= '{we: we, lsu_type: t, sign_ext: sx, addr: addr, wdata: wdata};
  do begin
    @(negedge clk_i);
  end while (!lsu_req_done_o);
  @(posedge clk_i);
  lsu_req_i <= 1'b0;
  do begin
    @(negedge clk_i);
  end while (!lsu_resp_o.resp_valid);
  last_resp = lsu_resp_o;
endtask

task automatic access_check(input string name, input logic we, input lsu_type_e t,
                            input logic sx, input logic [xlen_w-1:0] addr,
                            input logic [xlen_w-1:0] wdata);
  logic              fails;
  logic [3:0]        exp_flags;
  logic [xlen_w-1:0] exp_data;
  fails     = access_fails(t, addr);
  exp_data  = expect_load(t, sx, addr);
  exp_flags = {1'b1, !we && !fails, !we && fails, we && fails}; // valid, rdata, lerr, serr
  do_access(we, t, sx, addr, wdata);
  check_val({name, " busy"}, 32'd1, 32'(busy_o)); // final rvalid still in flight
  check_val({name, " flags"}, 32'(exp_flags),
            32'({last_resp.resp_valid, last_resp.rdata_valid, last_resp.load_err,
                 last_resp.store_err}));
  if (!we && !fails) check_val(name, exp_data, last_resp.rdata);
  @(negedge clk_i);
  check_val({name, " idle"}, 32'd0, 32'(busy_o)); // nothing left after the response
  if (we) store_ref(t, addr, wdata);
endtask

task automatic check_split(input string name, input lsu_type_e t, input logic [1:0] offset);
  logic [2*be_w-1:0] lanes;
  lanes = expect_be(t, offset);
  check_val({name, " transfers"}, 32'd2, 32'(be_log.size()));
  check_val({name, " first be"}, 32'(lanes[be_w-1:0]), 32'(be_log[0]));
  check_val({name, " second be"}, 32'(lanes[2*be_w-1:be_w]), 32'(be_log[1]));
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic test_reset();
  @(negedge clk_i);
  check_val("reset", 32'd0, 32'({bus_req_o.req, lsu_req_done_o, lsu_resp_o.resp_valid,
                                 lsu_resp_o.rdata_valid, lsu_resp_o.load_err,
                                 lsu_resp_o.store_err, busy_o}));
endtask

task automatic test_aligned();
  access_check("aligned store", 1'b1, lsu_word, 1'b0, 32'h40, 32'hcafe_f00d);
  check_val("aligned store transfers", 32'd1, 32'(be_log.size()));
  access_check("aligned load", 1'b0, lsu_word, 1'b0, 32'h40, '0);
  check_val("aligned load transfers", 32'd1, 32'(be_log.size()));
  check_val("aligned load data", 32'hcafe_f00d, last_resp.rdata);
endtask

task automatic test_sub_word();
  access_check("sign seed lo", 1'b1, lsu_word, 1'b0, 32'h80, 32'h807f_f112);
  access_check("sign seed hi", 1'b1, lsu_word, 1'b0, 32'h84, 32'h3ca5_0896);
  for (int unsigned off = 0; off < 4; off++) begin
    for (int unsigned sx = 0; sx < 2; sx++) begin
      access_check($sformatf("byte load off %0d sx %0d", off, sx), 1'b0, lsu_byte,
                   sx[0], 32'h80 + off, '0);
      access_check($sformatf("half load off %0d sx %0d", off, sx), 1'b0, lsu_half,
                   sx[0], 32'h80 + off, '0);
    end
  end
  access_check("byte store", 1'b1, lsu_byte, 1'b0, 32'h91, 32'h0000_00a5);
  access_check("half store", 1'b1, lsu_half, 1'b0, 32'h96, 32'h0000_beef);
  access_check("byte store lanes", 1'b0, lsu_word, 1'b0, 32'h90, '0);
  access_check("half store lanes", 1'b0, lsu_word, 1'b0, 32'h94, '0);
endtask

task automatic test_misaligned();
  logic [xlen_w-1:0] wdata;
  logic [xlen_w-1:0] addr;
  for (int unsigned off = 1; off < 4; off++) begin
    wdata = rand_next();
    addr  = 32'hc0 + 8 * off + off;
    access_check($sformatf("split store off %0d", off), 1'b1, lsu_word, 1'b0, addr, wdata);
    check_split($sformatf("split store off %0d", off), lsu_word, addr[1:0]);
    access_check($sformatf("split load off %0d", off), 1'b0, lsu_word, 1'b0, addr, '0);
    check_val($sformatf("split reload off %0d", off), wdata, last_resp.rdata);
  end
  access_check("split half store", 1'b1, lsu_half, 1'b0, 32'he3, 32'h0000_8421);
  check_split("split half store", lsu_half, 2'd3);
  access_check("split half load", 1'b0, lsu_half, 1'b0, 32'he3, '0);
  check_val("split half reload", 32'h0000_8421, last_resp.rdata);
endtask

task automatic test_bus_error();
  access_check("aligned err load", 1'b0, lsu_word, 1'b0, 32'h304, '0);
  check_val("aligned err addr", 32'h304, addr_last_o);
  access_check("first part err load", 1'b0, lsu_word, 1'b0, 32'h30e, '0);
  check_val("first part err addr", 32'h30e, addr_last_o);
  access_check("second part err load", 1'b0, lsu_half, 1'b1, 32'h2ff, '0);
  check_val("second part err addr", 32'h300, addr_last_o);
  access_check("err store", 1'b1, lsu_word, 1'b0, 32'h308, 32'h1234_5678);
endtask

// mixed traffic below the error window
task automatic test_random();
  logic [31:0] r;
  for (int unsigned i = 0; i < 50; i++) begin
    r = rand_next();
    access_check($sformatf("random access %0d", i), r[0], lsu_type_e'(2'(r[31:2] % 3)),
                 r[1], 32'(r[12:4]), rand_next());
  end
endtask

// ==== tb_lsu_top.sv ====
/*
 * Load/store unit testbench
 * Clock and reset, a word-bus memory model with random grant and rvalid
 * delays, a cycle limit and the directed test sequence.
 */
`timescale 1ns/1ps

module tb_lsu_top
  import lsu_pkg::*;
  import mem_bus_pkg::*;
();

  localparam int unsigned clk_period = 40;
  localparam int unsigned max_cycles = 2000; // about twice the full test length
  localparam int unsigned mem_bytes  = 1024; // addresses wrap at ten bits

  // response queued by the memory model at grant time
  typedef struct packed {
    logic [xlen_w-1:0] rdata;
    logic              err;
    logic [31:0]       due;   // first cycle in which rvalid may be driven
  } mem_rsp_t;

  logic              clk_i;
  logic              rst_ni;
  logic              lsu_req_i;
  lsu_req_t          lsu_req_data_i;
  logic              lsu_req_done_o;
  lsu_resp_t         lsu_resp_o;
  bus_req_t          bus_req_o;
  logic              data_gnt_i;
  logic              data_rvalid_i;
  logic              data_err_i;
  logic [xlen_w-1:0] data_rdata_i;
  logic [xlen_w-1:0] addr_last_o;
  logic              busy_o;

  logic [7:0]        mem_q [mem_bytes];   // contents seen by the bus
  logic [7:0]        ref_mem [mem_bytes]; // expected contents
  mem_rsp_t          rsp_fifo[$];         // granted, rvalid not yet sent
  logic [be_w-1:0]   be_log[$];           // enables of the current access
  logic [31:0]       rng;
  int unsigned       cyc;
  int unsigned       gnt_wait;            // cycles until the next grant
  lsu_resp_t         last_resp;

  lsu_top lsu_top_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_req_i      (lsu_req_i),
    .lsu_req_data_i (lsu_req_data_i),
    .lsu_req_done_o (lsu_req_done_o),
    .lsu_resp_o     (lsu_resp_o),
    .bus_req_o      (bus_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .data_rdata_i   (data_rdata_i),
    .addr_last_o    (addr_last_o),
    .busy_o         (busy_o)
  );

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] rand_next();
    rng = xorshift32(rng);
    return rng;
  endfunction

  `include "tb_lsu_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  // sample the bus mid cycle where req and gnt are settled
  always @(negedge clk_i) begin : bus_accept
    mem_rsp_t   rsp;
    logic [9:0] base;
    if (rst_ni && bus_req_o.req) begin
      if (data_gnt_i) begin
        base    = bus_req_o.addr[9:0];
        rsp.err = in_err_window(bus_req_o.addr);
        for (int unsigned l = 0; l < be_w; l++) begin
          rsp.rdata[8*l +: 8] = mem_q[base + 10'(l)]; // read before any write
          if (bus_req_o.we && bus_req_o.be[l] && !rsp.err) begin
            mem_q[base + 10'(l)] = bus_req_o.wdata[8*l +: 8];
          end
        end
        rsp.due = cyc + 32'd1 + (rand_next() & 32'd1); // one or two cycles later
        rsp_fifo.push_back(rsp);
        be_log.push_back(bus_req_o.be);
        gnt_wait = rand_next() % 4;
      end else if (gnt_wait != 0) begin
        gnt_wait--;                                    // back-pressure counts down
      end
    end
  end

  // grant, rvalid and cycle limit, driven on the rising edge
  always @(posedge clk_i) begin : bus_drive
    cyc++;
    if (cyc >= max_cycles) begin
      $display("Timeout after %0d cycles, the tests did not complete", cyc);
      $display("TEST FAIL");
      $fatal(1);
    end else begin
      data_gnt_i <= (gnt_wait == 0);
      if (rsp_fifo.size() != 0 && rsp_fifo[0].due <= cyc) begin
        data_rvalid_i <= 1'b1;                 // in order, one per transfer
        data_err_i    <= rsp_fifo[0].err;
        data_rdata_i  <= rsp_fifo[0].rdata;
        void'(rsp_fifo.pop_front());
      end else begin
        data_rvalid_i <= 1'b0;
        data_err_i    <= 1'b0;
        data_rdata_i  <= '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : test_seq
    rng            = 32'd30;
    cyc            = 0;
    gnt_wait       = 0;
    rst_ni         = 1'b0;
    lsu_req_i      = 1'b0;
    lsu_req_data_i = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_err_i     = 1'b0;
    data_rdata_i   = '0;
    for (int unsigned i = 0; i < mem_bytes; i++) begin
      mem_q[i]   = 8'((i * 29) ^ (i >> 3)); // pattern over all ten address bits
      ref_mem[i] = mem_q[i];
    end
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset();
    test_aligned();
    test_sub_word();
    test_misaligned();
    test_bus_error();
    test_random();
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== lsu_top.f ====
+incdir+.
lsu_pkg.sv
mem_bus_pkg.sv
lsu_ctrl.sv
lsu_addr_gen.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_top.sv
tb_lsu_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_lsu_top -f lsu_top.f \
  && ./obj_dir/Vtb_lsu_top || exit 1
